//--- hdl/sump_defs.svh
// SUMP front end constants
// Link credits, trigger stage count and the ID reply bytes

`ifndef SUMP_DEFS_SVH
`define SUMP_DEFS_SVH

// ####################
// Flow control
// ####################

// Credits granted by the link after reset
`define SUMP_TX_CREDITS 4

// ####################
// Trigger
// ####################

`define SUMP_STAGES 4

// ####################
// ID reply "1ALS"
// ####################

`define SUMP_ID_B0 8'h31
`define SUMP_ID_B1 8'h41
`define SUMP_ID_B2 8'h4C
`define SUMP_ID_B3 8'h53

`endif

//--- hdl/sump_cmd_pkg.sv
// SUMP command types
// Opcodes as sent by the host, decoded actions and the stage index

`default_nettype none

package sump_cmd_pkg;

  // ####################
  // Host opcodes
  // ####################

  typedef enum logic [7:0] {
    OPC_SOFT_RESET  = 8'h00,
    OPC_RUN         = 8'h01,
    OPC_ID          = 8'h02,
    OPC_XON         = 8'h11,
    OPC_XOFF        = 8'h13,
    OPC_SET_DIV     = 8'h80,
    OPC_SET_CNT     = 8'h81,  // Read count low, delay count high
    OPC_SET_FLAGS   = 8'h82,
    OPC_SET_TRG_MSK = 8'hC0,  // Stage in bits 3..2
    OPC_SET_TRG_VAL = 8'hC1,
    OPC_SET_TRG_CFG = 8'hC2
  } opcode_e;

  // One action per decoded command
  typedef enum logic [3:0] {
    ACT_NONE,
    ACT_SOFT_RESET,
    ACT_RUN,
    ACT_ID,
    ACT_XON,
    ACT_XOFF,
    ACT_SET_MASK,
    ACT_SET_VAL,
    ACT_SET_CFG,
    ACT_SET_DIV,
    ACT_SET_CNT,
    ACT_SET_FLAGS
  } action_e;

  typedef logic [1:0]  stage_t;
  typedef logic [31:0] param_t;  // Long command argument

endpackage

`default_nettype wire

//--- hdl/sump_cfg_pkg.sv
// SUMP configuration types
// Per-stage trigger words and the complete analyzer setup

`default_nettype none

`include "sump_defs.svh"

package sump_cfg_pkg;

  // ####################
  // Trigger stage
  // ####################

  typedef struct packed {
    logic [31:0] mask;
    logic [31:0] value;
    logic [31:0] cfg;   // Delay, level, channel, start
  } trig_stage_t;

  // ####################
  // Full configuration
  // ####################

  typedef struct packed {
    trig_stage_t [`SUMP_STAGES-1:0] trig;
    logic [23:0]                    divider;
    logic [15:0]                    read_cnt;
    logic [15:0]                    delay_cnt;
    logic [31:0]                    flags;
  } sump_cfg_t;

endpackage

`default_nettype wire

//--- hdl/sump_dec_if.sv
// Decoded command link
// Carries one action from the decoder to the register file and reply sender

`default_nettype none

interface sump_dec_if;
  import sump_cmd_pkg::*;

  logic    stb;     // One cycle per command
  action_e action;
  stage_t  stage;
  param_t  param;

  modport producer (
    output stb,
    output action,
    output stage,
    output param
  );

  modport consumer (
    input stb,
    input action,
    input stage,
    input param
  );

endinterface

`default_nettype wire

//--- hdl/sump_cmd_assembler.sv
// SUMP command assembler
// Gathers host bytes into short (1 byte) or long (opcode + 4 bytes) commands
// and emits each complete command with a single strobe

`default_nettype none

module sump_cmd_assembler (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 rx_valid_i,
  input  logic [7:0]           rx_data_i,
  output logic                 cmd_stb_o,
  output logic [7:0]           cmd_opc_o,
  output sump_cmd_pkg::param_t cmd_param_o
);
  import sump_cmd_pkg::*;

  logic [2:0] byte_cnt_q;  // 0 waits for opcode
  logic [7:0] opc_q;
  param_t     param_q;
  logic       stb_q;
  logic       last_byte;

  // Short opcode or fourth parameter byte
  assign last_byte = rx_valid_i &&
                     (((byte_cnt_q == 3'd0) && !rx_data_i[7]) || (byte_cnt_q == 3'd4));

  // ####################
  // Byte counter
  // ####################

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      byte_cnt_q <= 3'd0;
      stb_q      <= 1'b0;
    end else begin
      stb_q <= last_byte;
      if (rx_valid_i) begin
        if (byte_cnt_q == 3'd0) begin
          byte_cnt_q <= rx_data_i[7] ? 3'd1 : 3'd0;  // Long if bit 7 set
        end else if (byte_cnt_q == 3'd4) begin
          byte_cnt_q <= 3'd0;
        end else begin
          byte_cnt_q <= byte_cnt_q + 3'd1;
        end
      end
    end
  end

  // ####################
  // Opcode and parameter
  // ####################

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      if (byte_cnt_q == 3'd0) begin
        opc_q <= rx_data_i;
      end else begin
        param_q <= {rx_data_i, param_q[31:8]};  // LSB first
      end
    end
  end

  assign cmd_stb_o   = stb_q;
  assign cmd_opc_o   = opc_q;
  assign cmd_param_o = param_q;

endmodule

`default_nettype wire

//--- hdl/sump_indec.sv
// SUMP instruction decoder
// Maps each opcode onto one action plus the trigger stage; combinational

`default_nettype none

module sump_indec (
  input  logic                 cmd_stb_i,
  input  logic [7:0]           cmd_opc_i,
  input  sump_cmd_pkg::param_t cmd_param_i,
  sump_dec_if.producer         dec_o
);
  import sump_cmd_pkg::*;

  opcode_e opc_full;
  opcode_e opc_stg;  // Stage bits cleared

  assign opc_full = opcode_e'(cmd_opc_i);
  assign opc_stg  = opcode_e'(cmd_opc_i & 8'hF3);

  assign dec_o.stb   = cmd_stb_i;
  assign dec_o.stage = stage_t'(cmd_opc_i[3:2]);
  assign dec_o.param = cmd_param_i;

  // ####################
  // Opcode decoding
  // ####################

  always_comb begin
    dec_o.action = ACT_NONE;
    if (cmd_opc_i[7:6] == 2'b11) begin
      // Per-stage trigger commands
      case (opc_stg)
        OPC_SET_TRG_MSK: dec_o.action = ACT_SET_MASK;
        OPC_SET_TRG_VAL: dec_o.action = ACT_SET_VAL;
        OPC_SET_TRG_CFG: dec_o.action = ACT_SET_CFG;
        default:         dec_o.action = ACT_NONE;
      endcase
    end else begin
      case (opc_full)
        OPC_SOFT_RESET: dec_o.action = ACT_SOFT_RESET;
        OPC_RUN:        dec_o.action = ACT_RUN;
        OPC_ID:         dec_o.action = ACT_ID;
        OPC_XON:        dec_o.action = ACT_XON;
        OPC_XOFF:       dec_o.action = ACT_XOFF;
        OPC_SET_DIV:    dec_o.action = ACT_SET_DIV;
        OPC_SET_CNT:    dec_o.action = ACT_SET_CNT;
        OPC_SET_FLAGS:  dec_o.action = ACT_SET_FLAGS;
        default:        dec_o.action = ACT_NONE;  // Unknown opcode ignored
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/sump_cfg_regs.sv
// SUMP configuration register file
// Applies decoded actions to the trigger stages, divider, counts, flags
// and the armed state

`default_nettype none

module sump_cfg_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  sump_dec_if.consumer           dec_i,
  output sump_cfg_pkg::sump_cfg_t cfg_o,
  output logic                   armed_o
);
  import sump_cmd_pkg::*;
  import sump_cfg_pkg::*;

  sump_cfg_t cfg_q;
  logic      armed_q;

  // ####################
  // Register update
  // ####################

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q   <= '0;
      armed_q <= 1'b0;
    end else if (dec_i.stb) begin
      case (dec_i.action)
        ACT_SOFT_RESET: begin
          cfg_q   <= '0;
          armed_q <= 1'b0;
        end
        ACT_RUN: begin
          armed_q <= 1'b1;
        end
        ACT_SET_MASK: begin
          cfg_q.trig[dec_i.stage].mask <= dec_i.param;
        end
        ACT_SET_VAL: begin
          cfg_q.trig[dec_i.stage].value <= dec_i.param;
        end
        ACT_SET_CFG: begin
          cfg_q.trig[dec_i.stage].cfg <= dec_i.param;
        end
        ACT_SET_DIV: begin
          cfg_q.divider <= dec_i.param[23:0];
        end
        ACT_SET_CNT: begin
          cfg_q.read_cnt  <= dec_i.param[15:0];
          cfg_q.delay_cnt <= dec_i.param[31:16];
        end
        ACT_SET_FLAGS: begin
          cfg_q.flags <= dec_i.param;
        end
        default: begin
          // ID and XON/XOFF belong to the reply sender
          armed_q <= armed_q;
        end
      endcase
    end
  end

  // ####################
  // Outputs
  // ####################

  assign cfg_o   = cfg_q;
  assign armed_o = armed_q;

endmodule

`default_nettype wire

//--- hdl/sump_reply_tx.sv
// SUMP reply sender
// Returns the four ID bytes under XON/XOFF and link credit flow control

`default_nettype none

`include "sump_defs.svh"

module sump_reply_tx (
  input  logic         clk_i,
  input  logic         rst_n_i,
  sump_dec_if.consumer dec_i,
  input  logic         tx_credit_i,
  output logic         tx_valid_o,
  output logic [7:0]   tx_data_o
);
  import sump_cmd_pkg::*;

  localparam int unsigned       CRED_W   = $clog2(`SUMP_TX_CREDITS + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`SUMP_TX_CREDITS);

  logic [1:0]        idx_q;      // Next reply byte
  logic              pending_q;
  logic              xoff_q;
  logic [CRED_W-1:0] credit_q;
  logic              send;

  assign send       = pending_q && !xoff_q && (credit_q != '0);
  assign tx_valid_o = send;

  always_comb begin
    case (idx_q)
      2'd0:    tx_data_o = `SUMP_ID_B0;
      2'd1:    tx_data_o = `SUMP_ID_B1;
      2'd2:    tx_data_o = `SUMP_ID_B2;
      default: tx_data_o = `SUMP_ID_B3;
    endcase
  end

  // ####################
  // Reply control
  // ####################

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q     <= 2'd0;
      pending_q <= 1'b0;
      xoff_q    <= 1'b0;
    end else begin
      if (send) begin
        idx_q <= idx_q + 2'd1;  // Wraps to 0 after last byte
        if (idx_q == 2'd3) begin
          pending_q <= 1'b0;
        end
      end
      if (dec_i.stb) begin
        case (dec_i.action)
          ACT_ID: begin
            if (!pending_q) begin  // Dropped while busy
              pending_q <= 1'b1;
              idx_q     <= 2'd0;
            end
          end
          ACT_XON:  xoff_q <= 1'b0;
          ACT_XOFF: xoff_q <= 1'b1;
          ACT_SOFT_RESET: begin
            pending_q <= 1'b0;
            idx_q     <= 2'd0;
            xoff_q    <= 1'b0;
          end
          default: xoff_q <= xoff_q;
        endcase
      end
    end
  end

  // ####################
  // Link credits
  // ####################

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= CRED_MAX;
    end else if (tx_credit_i && !send) begin
      if (credit_q != CRED_MAX) begin
        credit_q <= credit_q + 1'b1;
      end
    end else if (send && !tx_credit_i) begin
      credit_q <= credit_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sump_ctrl_top.sv
// SUMP control front end
// Host byte stream in, configuration and ID replies out

`default_nettype none

module sump_ctrl_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Host bytes
  input  logic                    rx_valid_i,
  input  logic [7:0]              rx_data_i,
  // Configuration
  output sump_cfg_pkg::sump_cfg_t cfg_o,
  output logic                    armed_o,
  // Reply link
  input  logic                    tx_credit_i,
  output logic                    tx_valid_o,
  output logic [7:0]              tx_data_o
);
  import sump_cmd_pkg::*;

  logic       cmd_stb;
  logic [7:0] cmd_opc;
  param_t     cmd_param;

  sump_dec_if dec_if0 ();

  sump_cmd_assembler asm0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rx_valid_i  (rx_valid_i),
    .rx_data_i   (rx_data_i),
    .cmd_stb_o   (cmd_stb),
    .cmd_opc_o   (cmd_opc),
    .cmd_param_o (cmd_param)
  );

  sump_indec indec0 (
    .cmd_stb_i   (cmd_stb),
    .cmd_opc_i   (cmd_opc),
    .cmd_param_i (cmd_param),
    .dec_o       (dec_if0.producer)
  );

  sump_cfg_regs regs0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dec_i   (dec_if0.consumer),
    .cfg_o   (cfg_o),
    .armed_o (armed_o)
  );

  sump_reply_tx tx0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dec_i       (dec_if0.consumer),
    .tx_credit_i (tx_credit_i),
    .tx_valid_o  (tx_valid_o),
    .tx_data_o   (tx_data_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_sump_ctrl.sv
// SUMP control front end testbench
// Directed tests for configuration commands and the ID reply path

`default_nettype none

`include "sump_defs.svh"

module tb_sump_ctrl;
  timeunit 1ns;
  timeprecision 1ns;

  import sump_cmd_pkg::*;
  import sump_cfg_pkg::*;

  localparam int CYCLE_LIMIT = 4000;  // Summed test lengths plus margin
  localparam logic [7:0] ID_BYTES [4] = '{`SUMP_ID_B0, `SUMP_ID_B1, `SUMP_ID_B2, `SUMP_ID_B3};

  logic        clk, rst_n, rx_valid, tx_credit, armed, tx_valid;
  logic [7:0]  rx_data, tx_data;
  sump_cfg_t   cfg;
  sump_cfg_t   model_cfg;
  logic        model_armed;
  logic [7:0]  reply_q[$];
  logic [31:0] rng_state = 32'd47615;
  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  int          cycles = 0;

  sump_ctrl_top dut0 (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .rx_valid_i  (rx_valid),
    .rx_data_i   (rx_data),
    .cfg_o       (cfg),
    .armed_o     (armed),
    .tx_credit_i (tx_credit),
    .tx_valid_o  (tx_valid),
    .tx_data_o   (tx_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (tx_valid) begin
      reply_q.push_back(tx_data);  // Reply sink
    end
  end

  // ####################
  // Helpers
  // ####################

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic param_t rand_param();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Expected effect of one command
  function automatic void update_model(logic [7:0] opc, param_t p);
    case (opc)
      OPC_SOFT_RESET: begin
        model_cfg   = '0;
        model_armed = 1'b0;
      end
      OPC_RUN:       model_armed = 1'b1;
      OPC_SET_DIV:   model_cfg.divider = p[23:0];
      OPC_SET_CNT: begin
        model_cfg.read_cnt  = p[15:0];
        model_cfg.delay_cnt = p[31:16];
      end
      OPC_SET_FLAGS: model_cfg.flags = p;
      default: begin
        case (opc & 8'hF3)
          OPC_SET_TRG_MSK: model_cfg.trig[opc[3:2]].mask  = p;
          OPC_SET_TRG_VAL: model_cfg.trig[opc[3:2]].value = p;
          OPC_SET_TRG_CFG: model_cfg.trig[opc[3:2]].cfg   = p;
          default:         model_armed = model_armed;  // Unknown opcode
        endcase
      end
    endcase
  endfunction

  task automatic check_cfg(string name, sump_cfg_t got, sump_cfg_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_armed(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic send_byte(logic [7:0] b);
    @(negedge clk);
    rx_valid = 1'b1;
    rx_data  = b;
  endtask

  task automatic send_cmd(logic [7:0] opc, param_t p);
    send_byte(opc);
    if (opc[7]) begin
      for (int i = 0; i < 4; i++) begin
        send_byte(p[8*i +: 8]);  // LSB first
      end
    end
    update_model(opc, p);
  endtask

  // Idle the host, then wait out the two edges to the registers
  task automatic settle();
    @(negedge clk);
    rx_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic set_and_check(logic [7:0] opc);
    send_cmd(opc, rand_param());
    settle();
    check_cfg("cfg_o", cfg, model_cfg);
  endtask

  task automatic return_credits(int n);
    repeat (n) begin
      @(negedge clk);
      tx_credit = 1'b1;
      @(negedge clk);
      tx_credit = 1'b0;
    end
  endtask

  task automatic wait_reply(int n);
    int waited;
    waited = 0;
    while (reply_q.size() < n && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (reply_q.size() < n) begin
      $display("reply stalled at %0t: %0d of %0d bytes", $time, reply_q.size(), n);
      fail_cnt++;
    end
  endtask

  task automatic no_reply(int n, string when);
    repeat (n) @(negedge clk);
    if (reply_q.size() != 0) begin
      $display("unexpected reply bytes %s at %0t", when, $time);
      fail_cnt++;
      reply_q.delete();
    end
  endtask

  task automatic expect_id();
    wait_reply(4);
    for (int i = 0; i < 4 && reply_q.size() > 0; i++) begin
      check_byte("tx_data_o", reply_q.pop_front(), ID_BYTES[i]);
    end
  endtask

  // ####################
  // Tests
  // ####################

  task automatic test_config_fields();
    check_cfg("cfg_o", cfg, '0);
    check_armed("armed_o", armed, 1'b0);
    set_and_check(OPC_SET_DIV);
    set_and_check(OPC_SET_CNT);
    set_and_check(OPC_SET_FLAGS);
    for (int s = 0; s < `SUMP_STAGES; s++) begin
      set_and_check(OPC_SET_TRG_MSK | 8'(s << 2));
      set_and_check(OPC_SET_TRG_VAL | 8'(s << 2));
      set_and_check(OPC_SET_TRG_CFG | 8'(s << 2));
    end
    no_reply(4, "after configuration");
  endtask

  task automatic test_run_reset_unknown();
    send_cmd(OPC_RUN, '0);
    settle();
    check_armed("armed_o", armed, 1'b1);
    send_cmd(OPC_SOFT_RESET, '0);
    settle();
    check_cfg("cfg_o", cfg, '0);
    check_armed("armed_o", armed, 1'b0);
    set_and_check(OPC_SET_FLAGS);
    send_cmd(OPC_RUN, '0);
    send_cmd(8'h05, '0);
    send_cmd(8'h90, rand_param());
    send_cmd(8'hC3, rand_param());  // Stage opcode with unused low bits
    settle();
    check_cfg("cfg_o", cfg, model_cfg);
    check_armed("armed_o", armed, model_armed);
  endtask

  task automatic test_back_to_back();
    send_cmd(OPC_SET_DIV, rand_param());
    send_cmd(OPC_SET_TRG_MSK | 8'h08, rand_param());
    send_cmd(OPC_SOFT_RESET, '0);
    send_cmd(OPC_SET_FLAGS, rand_param());
    send_cmd(8'h05, '0);
    send_cmd(OPC_SET_CNT, rand_param());
    send_cmd(OPC_RUN, '0);
    send_cmd(OPC_SET_TRG_CFG | 8'h0C, rand_param());
    send_cmd(OPC_SET_TRG_VAL, rand_param());
    settle();
    check_cfg("cfg_o", cfg, model_cfg);
    check_armed("armed_o", armed, model_armed);
  endtask

  task automatic test_id_reply();
    send_cmd(OPC_ID, '0);
    settle();
    expect_id();
    return_credits(`SUMP_TX_CREDITS);
  endtask

  task automatic test_credit_stall();
    send_cmd(OPC_ID, '0);
    settle();
    expect_id();
    send_cmd(OPC_ID, '0);
    settle();
    no_reply(20, "without credit");
    for (int i = 0; i < 4; i++) begin
      return_credits(1);
      wait_reply(1);
      repeat (5) @(negedge clk);
      if (reply_q.size() != 1) begin
        $display("credit %0d released %0d bytes instead of one", i, reply_q.size());
        fail_cnt++;
      end
      if (reply_q.size() > 0) begin
        check_byte("tx_data_o", reply_q.pop_front(), ID_BYTES[i]);
      end
      reply_q.delete();
    end
  endtask

  task automatic test_xoff_hold();
    return_credits(`SUMP_TX_CREDITS);
    send_cmd(OPC_XOFF, '0);
    send_cmd(OPC_ID, '0);
    settle();
    no_reply(20, "under XOFF");
    send_cmd(OPC_XON, '0);
    settle();
    expect_id();
    no_reply(5, "after the XON reply");
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    rx_valid    = 1'b0;
    rx_data     = 8'h00;
    tx_credit   = 1'b0;
    model_cfg   = '0;
    model_armed = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_config_fields();
    test_run_reset_unknown();
    test_back_to_back();
    test_id_reply();
    test_credit_stall();
    test_xoff_hold();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
hdl/sump_cmd_pkg.sv
hdl/sump_cfg_pkg.sv
hdl/sump_dec_if.sv
hdl/sump_cmd_assembler.sv
hdl/sump_indec.sv
hdl/sump_cfg_regs.sv
hdl/sump_reply_tx.sv
hdl/sump_ctrl_top.sv
testbench/tb_sump_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SUMP control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary -Wno-fatal -f compile.f --top-module tb_sump_ctrl -Mdir obj_dir

./obj_dir/Vtb_sump_ctrl | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi

echo "Simulation passed"
